/* ctrl_block.f */
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/inst_buffer.sv
hdl/inst_decoder.sv
hdl/reg_rename.sv
hdl/reorder_buffer.sv
hdl/ctrl_block.sv
verification/ctrl_block_checker.sv
verification/ctrl_block_tb.sv

/* verification/ctrl_block_tb.sv */
`timescale 1ns/1ps

module ctrl_block_tb;

    localparam int NUM_ROWS = 24;
    localparam int TIMEOUT  = NUM_ROWS * 40 + 200;

    logic                             clk = 1'b0;
    logic                             i_rst_n;
    logic [core_pkg::FETCH_WIDTH-1:0] i_inst_vld;
    isa_pkg::inst_word_t              i_inst [core_pkg::FETCH_WIDTH];
    logic                             i_wb_vld;
    core_pkg::rob_idx_t               i_wb_rob_idx;
    logic                             o_stall;
    logic [core_pkg::FETCH_WIDTH-1:0] o_disp_vld;
    core_pkg::disp_info_t             o_disp_info [core_pkg::FETCH_WIDTH];
    logic                             o_commit_vld;
    core_pkg::commit_info_t           o_commit_info;

    logic [1:0]  row_vld [NUM_ROWS];
    logic [31:0] row_w0 [NUM_ROWS];
    logic [31:0] row_w1 [NUM_ROWS];
    logic [3:0]  pending [$];
    logic [15:0] lfsr = 16'd75;
    logic        hold_wb;
    int          cycles = 0;
    int          total = 0;
    int          stall_seen = 0;
    int          harness_err = 0;
    int          wb_go;
    int          wb_pick;

    always #4 clk = ~clk;

    ctrl_block u_ctrl_block (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_inst_vld    ( i_inst_vld    ),
        .i_inst        ( i_inst        ),
        .i_wb_vld      ( i_wb_vld      ),
        .i_wb_rob_idx  ( i_wb_rob_idx  ),
        .o_stall       ( o_stall       ),
        .o_disp_vld    ( o_disp_vld    ),
        .o_disp_info   ( o_disp_info   ),
        .o_commit_vld  ( o_commit_vld  ),
        .o_commit_info ( o_commit_info )
    );

    ctrl_block_checker u_checker (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_inst_vld    ( i_inst_vld    ),
        .i_stall       ( o_stall       ),
        .i_disp_vld    ( o_disp_vld    ),
        .i_disp_info   ( o_disp_info   ),
        .i_commit_vld  ( o_commit_vld  ),
        .i_commit_info ( o_commit_info )
    );

    function automatic logic [31:0] enc_r(input int rd, input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int rd, input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), 3'd0, 5'(rd), 7'h13};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'h37};
    endfunction

    // branch opcode is outside the supported set
    function automatic logic [31:0] enc_bad(input int rd);
        return {7'h15, 5'd3, 5'd2, 3'd1, 5'(rd), 7'h63};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic set_row(input int r, input logic [1:0] vld, input logic [31:0] w0,
                           input logic [31:0] w1);
        row_vld[r] = vld;
        row_w0[r]  = w0;
        row_w1[r]  = w1;
    endtask

    task automatic fill_table();
        set_row(0, 2'b11, enc_i(1, 0, 12'h005), enc_r(2, 1, 1));
        set_row(1, 2'b01, enc_lui(3, 20'hABCDE), 32'h0);
        set_row(2, 2'b10, 32'h0, enc_i(4, 3, 12'hFFF));
        set_row(3, 2'b11, enc_r(0, 1, 2), enc_bad(5));
        set_row(4, 2'b11, enc_r(5, 5, 4), enc_i(5, 5, 12'h001));
        set_row(5, 2'b01, enc_bad(7), 32'h0);
        // burst of writing pairs to run out of ROB slots
        for (int r = 6; r < 18; r++) begin
            set_row(r, 2'b11, enc_i(r, r - 1, 12'(r)), enc_r(r + 8, r, r - 2));
        end
        set_row(18, 2'b11, enc_lui(0, 20'h12345), enc_r(1, 2, 3));
        set_row(19, 2'b01, enc_i(2, 1, 12'h800), 32'h0);
        set_row(20, 2'b10, 32'h0, enc_bad(9));
        set_row(21, 2'b11, enc_r(1, 1, 1), enc_r(1, 1, 1));
        set_row(22, 2'b11, enc_i(31, 31, 12'h7FF), enc_lui(31, 20'hFFFFF));
        set_row(23, 2'b01, enc_r(3, 31, 1), 32'h0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, dispatch or commit stopped", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // random out of order writeback of dispatched entries
    always @(negedge clk) begin
        if (i_rst_n) begin
            for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
                if (o_disp_vld[k] && o_disp_info[k].op != isa_pkg::ILLEGAL) begin
                    pending.push_back(o_disp_info[k].rob_idx);
                end
            end
            i_wb_vld = 1'b0;
            if (!hold_wb && pending.size() > 0) begin
                take_bits(1, wb_go);
                if (wb_go != 0) begin
                    take_bits(4, wb_pick);
                    wb_pick      = wb_pick % pending.size();
                    i_wb_rob_idx = pending[wb_pick];
                    i_wb_vld     = 1'b1;
                    pending.delete(wb_pick);
                end
            end
        end
    end

    initial begin
        i_rst_n      = 1'b0;
        i_inst_vld   = '0;
        i_inst[0]    = '0;
        i_inst[1]    = '0;
        i_wb_vld     = 1'b0;
        i_wb_rob_idx = '0;
        hold_wb     <= 1'b0;
        fill_table();
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            if (r == 6) begin
                hold_wb <= 1'b1;
            end
            if (r == 18) begin
                hold_wb <= 1'b0;
            end
            i_inst_vld = row_vld[r];
            i_inst[0]  = row_w0[r];
            i_inst[1]  = row_w1[r];
            // the row stays on the inputs until the buffer has room
            while (o_stall) begin
                stall_seen++;
                if (hold_wb && stall_seen >= 12) begin
                    hold_wb <= 1'b0;
                end
                @(negedge clk);
            end
            for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
                if (row_vld[r][k]) begin
                    u_checker.expect_inst(k == 0 ? row_w0[r] : row_w1[r]);
                    total++;
                end
            end
        end
        @(negedge clk);
        i_inst_vld = '0;

        while (u_checker.commit_cnt < total) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (stall_seen == 0) begin
            harness_err++;
            $display("o_stall never rose while writeback was withheld");
        end
        if (u_checker.disp_cnt != total || u_checker.commit_cnt != total) begin
            harness_err++;
            $display("%0d instructions sent but %0d dispatched and %0d committed",
                     total, u_checker.disp_cnt, u_checker.commit_cnt);
        end
        $display("errors: checker %0d, harness %0d", u_checker.err_cnt, harness_err);
        if (u_checker.err_cnt + harness_err == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/ctrl_block_checker.sv */
`timescale 1ns/1ps

module ctrl_block_checker (
    input logic                             clk,
    input logic                             i_rst_n,
    input logic [core_pkg::FETCH_WIDTH-1:0] i_inst_vld,
    input logic                             i_stall,
    input logic [core_pkg::FETCH_WIDTH-1:0] i_disp_vld,
    input core_pkg::disp_info_t             i_disp_info [core_pkg::FETCH_WIDTH],
    input logic                             i_commit_vld,
    input core_pkg::commit_info_t           i_commit_info
);

    // instruction words in program order from the stimulus loop
    logic [31:0]            inst_q [$];
    core_pkg::commit_info_t cmt_q [$];
    logic [5:0]             cmt_old_q [$];
    logic [5:0]             map [core_pkg::ARCH_REGS];
    logic [5:0]             free_q [$];
    logic [3:0]             exp_rob;
    int                     err_cnt = 0;
    int                     disp_cnt = 0;
    int                     commit_cnt = 0;
    int                     ibuf_cnt = 0;
    int                     ibuf_enq = 0;

    // reset state of the rename tables
    initial begin
        for (int r = 0; r < core_pkg::ARCH_REGS; r++) begin
            map[r] = 6'(r);
        end
        for (int f = core_pkg::ARCH_REGS; f < core_pkg::PHYS_REGS; f++) begin
            free_q.push_back(6'(f));
        end
        exp_rob = '0;
    end

    task automatic expect_inst(input logic [31:0] w);
        inst_q.push_back(w);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("** Error: %s expected %h got %h", name, exp, act);
        end
    endtask

    // buffer occupancy where each dequeue shows up as o_disp_vld one cycle later
    task automatic check_stall();
        int   n_disp;
        int   n_enq;
        logic exp_stall;
        n_disp = 0;
        n_enq  = 0;
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            n_disp = n_disp + int'(i_disp_vld[k]);
            n_enq  = n_enq + int'(i_inst_vld[k]);
        end
        ibuf_cnt  = ibuf_cnt + ibuf_enq - n_disp;
        exp_stall = (core_pkg::IBUF_DEPTH - ibuf_cnt) < 2;
        check_val("o_stall", exp_stall, i_stall);
        ibuf_enq  = exp_stall ? 0 : n_enq;
    endtask

    task automatic check_dispatch(input int k, input core_pkg::disp_info_t d);
        logic [31:0]            w;
        isa_pkg::fu_op_t        op;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [19:0]            imm;
        logic                   wr;
        logic                   use2;
        logic [5:0]             pdst;
        logic [5:0]             old;
        core_pkg::commit_info_t c;
        if (inst_q.size() == 0) begin
            err_cnt++;
            $display("dispatch on lane %0d with no instruction left to expect", k);
            return;
        end
        w    = inst_q.pop_front();
        rd   = w[11:7];
        rs1  = w[19:15];
        rs2  = w[24:20];
        imm  = '0;
        use2 = 1'b0;
        pdst = '0;
        case (w[6:0])
            7'h33: begin
                op   = isa_pkg::ALU_REG;
                use2 = 1'b1;
            end
            7'h13: begin
                op  = isa_pkg::ALU_IMM;
                imm = {{8{w[31]}}, w[31:20]};
            end
            7'h37: begin
                op  = isa_pkg::ALU_LUI;
                imm = w[31:12];
            end
            default: op = isa_pkg::ILLEGAL;
        endcase
        wr  = (op != isa_pkg::ILLEGAL) && (rd != 5'd0);
        old = map[rd];
        check_val($sformatf("o_disp_info[%0d].op", k), op, d.op);
        check_val($sformatf("o_disp_info[%0d].rd", k), rd, d.rd);
        check_val($sformatf("o_disp_info[%0d].imm", k), imm, d.imm);
        check_val($sformatf("o_disp_info[%0d].use_rs2", k), use2, d.use_rs2);
        check_val($sformatf("o_disp_info[%0d].writes_rd", k), wr, d.writes_rd);
        check_val($sformatf("o_disp_info[%0d].rob_idx", k), exp_rob, d.rob_idx);
        if (op == isa_pkg::ALU_REG || op == isa_pkg::ALU_IMM) begin
            check_val($sformatf("o_disp_info[%0d].psrc1", k), map[rs1], d.psrc1);
        end
        if (use2) begin
            check_val($sformatf("o_disp_info[%0d].psrc2", k), map[rs2], d.psrc2);
        end
        check_val($sformatf("o_disp_info[%0d].old_pdst", k), old, d.old_pdst);
        if (wr) begin
            if (free_q.size() == 0) begin
                err_cnt++;
                $display("dispatch on lane %0d took a register the model free list lacks", k);
            end else begin
                pdst = free_q.pop_front();
                check_val($sformatf("o_disp_info[%0d].pdst", k), pdst, d.pdst);
                map[rd] = pdst;
            end
        end
        c.rob_idx   = exp_rob;
        c.rd        = rd;
        c.pdst      = pdst;
        c.writes_rd = wr;
        c.illegal   = op == isa_pkg::ILLEGAL;
        cmt_q.push_back(c);
        cmt_old_q.push_back(old);
        exp_rob++;
        disp_cnt++;
    endtask

    task automatic check_commit(input core_pkg::commit_info_t c);
        core_pkg::commit_info_t e;
        logic [5:0]             old;
        if (cmt_q.size() == 0) begin
            err_cnt++;
            $display("commit seen with no dispatched instruction outstanding");
            return;
        end
        e   = cmt_q.pop_front();
        old = cmt_old_q.pop_front();
        check_val("o_commit_info.rob_idx", e.rob_idx, c.rob_idx);
        check_val("o_commit_info.rd", e.rd, c.rd);
        check_val("o_commit_info.writes_rd", e.writes_rd, c.writes_rd);
        check_val("o_commit_info.illegal", e.illegal, c.illegal);
        if (e.writes_rd) begin
            check_val("o_commit_info.pdst", e.pdst, c.pdst);
            // previous mapping returns to the tail of the free list
            free_q.push_back(old);
        end
        commit_cnt++;
    endtask

    // commits go first so freed registers reach the model before later dispatches
    always @(posedge clk) begin
        if (i_rst_n) begin
            check_stall();
            if (i_commit_vld) begin
                check_commit(i_commit_info);
            end
            for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
                if (i_disp_vld[k]) begin
                    check_dispatch(k, i_disp_info[k]);
                end
            end
        end else begin
            ibuf_cnt = 0;
            ibuf_enq = 0;
        end
    end

endmodule

/* hdl/ctrl_block.sv */
`timescale 1ns/1ps

module ctrl_block (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [core_pkg::FETCH_WIDTH-1:0] i_inst_vld,
    input  isa_pkg::inst_word_t              i_inst [core_pkg::FETCH_WIDTH],
    input  logic                             i_wb_vld,
    input  core_pkg::rob_idx_t               i_wb_rob_idx,
    output logic                             o_stall,
    output logic [core_pkg::FETCH_WIDTH-1:0] o_disp_vld,
    output core_pkg::disp_info_t             o_disp_info [core_pkg::FETCH_WIDTH],
    output logic                             o_commit_vld,
    output core_pkg::commit_info_t           o_commit_info
);

    logic [core_pkg::FETCH_WIDTH-1:0] ibuf_vld;
    isa_pkg::inst_word_t              ibuf_data [core_pkg::FETCH_WIDTH];
    logic [core_pkg::FETCH_WIDTH-1:0] deq_mask;
    isa_pkg::dec_info_t               dec_info [core_pkg::FETCH_WIDTH];
    core_pkg::rob_cnt_t               rob_free;
    core_pkg::rob_idx_t               rob_tail;
    logic [core_pkg::FETCH_WIDTH-1:0] alloc_vld;
    core_pkg::rob_entry_t             alloc_entry [core_pkg::FETCH_WIDTH];
    logic                             free_vld;
    core_pkg::pr_idx_t                free_pdst;

    inst_buffer u_inst_buffer (
        .clk        ( clk        ),
        .i_rst_n    ( i_rst_n    ),
        .i_enq_vld  ( i_inst_vld ),
        .i_enq_data ( i_inst     ),
        .i_deq_mask ( deq_mask   ),
        .o_stall    ( o_stall    ),
        .o_deq_vld  ( ibuf_vld   ),
        .o_deq_data ( ibuf_data  )
    );

    // one decoder per lane
    for (genvar k = 0; k < core_pkg::FETCH_WIDTH; k++) begin : gen_dec
        inst_decoder u_inst_decoder (
            .i_inst ( ibuf_data[k] ),
            .o_dec  ( dec_info[k]  )
        );
    end

    reg_rename u_reg_rename (
        .clk           ( clk         ),
        .i_rst_n       ( i_rst_n     ),
        .i_dec_vld     ( ibuf_vld    ),
        .i_dec         ( dec_info    ),
        .i_rob_free    ( rob_free    ),
        .i_rob_tail    ( rob_tail    ),
        .i_free_vld    ( free_vld    ),
        .i_free_pdst   ( free_pdst   ),
        .o_deq_mask    ( deq_mask    ),
        .o_alloc_vld   ( alloc_vld   ),
        .o_alloc_entry ( alloc_entry ),
        .o_disp_vld    ( o_disp_vld  ),
        .o_disp_info   ( o_disp_info )
    );

    reorder_buffer u_reorder_buffer (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_alloc_vld   ( alloc_vld     ),
        .i_alloc_entry ( alloc_entry   ),
        .i_wb_vld      ( i_wb_vld      ),
        .i_wb_rob_idx  ( i_wb_rob_idx  ),
        .o_free        ( rob_free      ),
        .o_tail        ( rob_tail      ),
        .o_commit_vld  ( o_commit_vld  ),
        .o_commit_info ( o_commit_info ),
        .o_free_vld    ( free_vld      ),
        .o_free_pdst   ( free_pdst     )
    );

endmodule

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [core_pkg::FETCH_WIDTH-1:0] i_alloc_vld,
    input  core_pkg::rob_entry_t             i_alloc_entry [core_pkg::FETCH_WIDTH],
    input  logic                             i_wb_vld,
    input  core_pkg::rob_idx_t               i_wb_rob_idx,
    output core_pkg::rob_cnt_t               o_free,
    output core_pkg::rob_idx_t               o_tail,
    output logic                             o_commit_vld,
    output core_pkg::commit_info_t           o_commit_info,
    output logic                             o_free_vld,
    output core_pkg::pr_idx_t                o_free_pdst
);

    core_pkg::rob_entry_t rob_q [core_pkg::ROB_SIZE];
    core_pkg::rob_idx_t   head;
    core_pkg::rob_idx_t   tail;
    core_pkg::rob_cnt_t   count;
    core_pkg::rob_cnt_t   n_alloc;
    core_pkg::rob_entry_t head_entry;
    logic                 commit_fire;

    always_comb begin
        n_alloc = '0;
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            n_alloc = n_alloc + core_pkg::rob_cnt_t'(i_alloc_vld[k]);
        end
    end

    assign head_entry  = rob_q[head];
    // oldest entry retires once it is done
    assign commit_fire = (count != '0) && head_entry.done;

    assign o_free = core_pkg::rob_cnt_t'(core_pkg::ROB_SIZE) - count;
    assign o_tail = tail;

    always_ff @(posedge clk) begin
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            if (i_alloc_vld[k]) begin
                rob_q[tail + core_pkg::rob_idx_t'(k)] <= i_alloc_entry[k];
            end
        end
        // completion from the execution units
        if (i_wb_vld) begin
            rob_q[i_wb_rob_idx].done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail <= tail + core_pkg::rob_idx_t'(n_alloc);
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            count <= count + n_alloc - core_pkg::rob_cnt_t'(commit_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_commit_vld <= 1'b0;
            o_free_vld   <= 1'b0;
        end else begin
            o_commit_vld <= commit_fire;
            // the previous mapping is dead once its overwriter retires
            o_free_vld   <= commit_fire && head_entry.writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        o_commit_info.rob_idx   <= head;
        o_commit_info.rd        <= head_entry.rd;
        o_commit_info.pdst      <= head_entry.pdst;
        o_commit_info.writes_rd <= head_entry.writes_rd;
        o_commit_info.illegal   <= head_entry.illegal;
        o_free_pdst             <= head_entry.old_pdst;
    end

endmodule

/* hdl/reg_rename.sv */
`timescale 1ns/1ps

module reg_rename (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [core_pkg::FETCH_WIDTH-1:0] i_dec_vld,
    input  isa_pkg::dec_info_t               i_dec [core_pkg::FETCH_WIDTH],
    input  core_pkg::rob_cnt_t               i_rob_free,
    input  core_pkg::rob_idx_t               i_rob_tail,
    input  logic                             i_free_vld,
    input  core_pkg::pr_idx_t                i_free_pdst,
    output logic [core_pkg::FETCH_WIDTH-1:0] o_deq_mask,
    output logic [core_pkg::FETCH_WIDTH-1:0] o_alloc_vld,
    output core_pkg::rob_entry_t             o_alloc_entry [core_pkg::FETCH_WIDTH],
    output logic [core_pkg::FETCH_WIDTH-1:0] o_disp_vld,
    output core_pkg::disp_info_t             o_disp_info [core_pkg::FETCH_WIDTH]
);

    core_pkg::pr_idx_t    map_table [core_pkg::ARCH_REGS];
    core_pkg::pr_idx_t    free_list [core_pkg::FREE_REGS];
    core_pkg::fl_ptr_t    fl_head;
    core_pkg::fl_ptr_t    fl_tail;
    core_pkg::fl_cnt_t    fl_cnt;
    core_pkg::fl_cnt_t    n_preg;
    core_pkg::fl_cnt_t    pop_cnt;
    core_pkg::rob_cnt_t   n_lane;
    logic [core_pkg::FETCH_WIDTH-1:0] need_preg;
    logic                 accept;
    core_pkg::disp_info_t ren [core_pkg::FETCH_WIDTH];

    // resources for the whole group, else take nothing
    always_comb begin
        n_preg = '0;
        n_lane = '0;
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            need_preg[k] = i_dec_vld[k] && i_dec[k].writes_rd;
            n_preg = n_preg + core_pkg::fl_cnt_t'(need_preg[k]);
            n_lane = n_lane + core_pkg::rob_cnt_t'(i_dec_vld[k]);
        end
        accept = (|i_dec_vld) && (fl_cnt >= n_preg) && (i_rob_free >= n_lane);
    end

    always_comb begin
        pop_cnt = '0;
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            ren[k]           = '0;
            ren[k].op        = i_dec[k].op;
            ren[k].rd        = i_dec[k].rd;
            ren[k].imm       = i_dec[k].imm;
            ren[k].use_rs2   = i_dec[k].use_rs2;
            ren[k].writes_rd = i_dec[k].writes_rd;
            ren[k].rob_idx   = i_rob_tail + core_pkg::rob_idx_t'(k);
            ren[k].psrc1     = map_table[i_dec[k].rs1];
            ren[k].psrc2     = map_table[i_dec[k].rs2];
            ren[k].old_pdst  = map_table[i_dec[k].rd];
            // younger lanes see the new mappings of older ones
            for (int j = 0; j < k; j++) begin
                if (need_preg[j] && (i_dec[j].rd == i_dec[k].rs1)) begin
                    ren[k].psrc1 = ren[j].pdst;
                end
                if (need_preg[j] && (i_dec[j].rd == i_dec[k].rs2)) begin
                    ren[k].psrc2 = ren[j].pdst;
                end
                if (need_preg[j] && (i_dec[j].rd == i_dec[k].rd)) begin
                    ren[k].old_pdst = ren[j].pdst;
                end
            end
            if (need_preg[k]) begin
                ren[k].pdst = free_list[fl_head + core_pkg::fl_ptr_t'(pop_cnt)];
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    // rob entries go out on the accepting edge
    always_comb begin
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            o_deq_mask[k]              = accept && i_dec_vld[k];
            o_alloc_vld[k]             = accept && i_dec_vld[k];
            o_alloc_entry[k].rd        = ren[k].rd;
            o_alloc_entry[k].pdst      = ren[k].pdst;
            o_alloc_entry[k].old_pdst  = ren[k].old_pdst;
            o_alloc_entry[k].writes_rd = ren[k].writes_rd;
            // nothing will write back an illegal op
            o_alloc_entry[k].done      = ren[k].op == isa_pkg::ILLEGAL;
            o_alloc_entry[k].illegal   = ren[k].op == isa_pkg::ILLEGAL;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < core_pkg::ARCH_REGS; r++) begin
                map_table[r] <= core_pkg::pr_idx_t'(r);
            end
            for (int f = 0; f < core_pkg::FREE_REGS; f++) begin
                free_list[f] <= core_pkg::pr_idx_t'(core_pkg::ARCH_REGS + f);
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_cnt  <= core_pkg::fl_cnt_t'(core_pkg::FREE_REGS);
        end else begin
            if (accept) begin
                for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
                    if (need_preg[k]) begin
                        map_table[i_dec[k].rd] <= ren[k].pdst;
                    end
                end
                fl_head <= fl_head + core_pkg::fl_ptr_t'(n_preg);
            end
            // registers released by commit
            if (i_free_vld) begin
                free_list[fl_tail] <= i_free_pdst;
                fl_tail <= fl_tail + 1'b1;
            end
            fl_cnt <= fl_cnt + core_pkg::fl_cnt_t'(i_free_vld)
                    - (accept ? n_preg : core_pkg::fl_cnt_t'(0));
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_disp_vld <= '0;
        end else begin
            o_disp_vld <= o_deq_mask;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            o_disp_info[k] <= ren[k];
        end
    end

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_word_t i_inst,
    output isa_pkg::dec_info_t  o_dec
);

    always_comb begin
        o_dec     = '0;
        o_dec.op  = isa_pkg::ILLEGAL;
        // register fields sit at the same place in every format
        o_dec.rd  = i_inst.r.rd;
        o_dec.rs1 = i_inst.r.rs1;

        case (i_inst.r.opcode)
            isa_pkg::OPC_OP: begin
                o_dec.op      = isa_pkg::ALU_REG;
                o_dec.rs2     = i_inst.r.rs2;
                o_dec.use_rs2 = 1'b1;
            end
            isa_pkg::OPC_OP_IMM: begin
                o_dec.op  = isa_pkg::ALU_IMM;
                // sign extend the 12 bit field
                o_dec.imm = {{8{i_inst.i.imm[11]}}, i_inst.i.imm};
            end
            isa_pkg::OPC_LUI: begin
                o_dec.op  = isa_pkg::ALU_LUI;
                // upper 20 bits of the word
                o_dec.imm = {i_inst.i.imm, i_inst.i.rs1, i_inst.i.funct3};
            end
            default: begin
                o_dec.op = isa_pkg::ILLEGAL;
            end
        endcase

        // x0 as destination means no write at all
        o_dec.writes_rd = (o_dec.op != isa_pkg::ILLEGAL) && (o_dec.rd != '0);
    end

endmodule

/* hdl/inst_buffer.sv */
`timescale 1ns/1ps

module inst_buffer (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [core_pkg::FETCH_WIDTH-1:0] i_enq_vld,
    input  isa_pkg::inst_word_t              i_enq_data [core_pkg::FETCH_WIDTH],
    input  logic [core_pkg::FETCH_WIDTH-1:0] i_deq_mask,
    output logic                             o_stall,
    output logic [core_pkg::FETCH_WIDTH-1:0] o_deq_vld,
    output isa_pkg::inst_word_t              o_deq_data [core_pkg::FETCH_WIDTH]
);

    isa_pkg::inst_word_t mem [core_pkg::IBUF_DEPTH];
    core_pkg::ibuf_ptr_t head_ptr;
    core_pkg::ibuf_ptr_t tail_ptr;
    core_pkg::ibuf_cnt_t count;
    core_pkg::ibuf_cnt_t n_enq;
    core_pkg::ibuf_cnt_t n_deq;
    core_pkg::ibuf_ptr_t wr_ptr [core_pkg::FETCH_WIDTH];

    // room for a full pair or nothing
    assign o_stall = (core_pkg::ibuf_cnt_t'(core_pkg::IBUF_DEPTH) - count)
                   < core_pkg::ibuf_cnt_t'(core_pkg::FETCH_WIDTH);

    // valid lanes pack down in lane order
    always_comb begin
        n_enq = '0;
        n_deq = '0;
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            wr_ptr[k] = tail_ptr + core_pkg::ibuf_ptr_t'(n_enq);
            n_enq = n_enq + core_pkg::ibuf_cnt_t'(i_enq_vld[k]);
            n_deq = n_deq + core_pkg::ibuf_cnt_t'(i_deq_mask[k]);
        end
    end

    // oldest words at the head
    always_comb begin
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            o_deq_vld[k]  = count > k;
            o_deq_data[k] = mem[head_ptr + core_pkg::ibuf_ptr_t'(k)];
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < core_pkg::FETCH_WIDTH; k++) begin
            if (!o_stall && i_enq_vld[k]) begin
                mem[wr_ptr[k]] <= i_enq_data[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            head_ptr <= head_ptr + core_pkg::ibuf_ptr_t'(n_deq);
            if (!o_stall) begin
                tail_ptr <= tail_ptr + core_pkg::ibuf_ptr_t'(n_enq);
                count    <= count + n_enq - n_deq;
            end else begin
                count <= count - n_deq;
            end
        end
    end

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    // pipeline widths and storage sizes
    localparam int FETCH_WIDTH = 2;
    localparam int ARCH_REGS   = 32;
    localparam int PHYS_REGS   = 64;
    localparam int ROB_SIZE    = 16;
    localparam int IBUF_DEPTH  = 8;

    // physical registers not holding an architectural value at reset
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    typedef logic [$clog2(PHYS_REGS)-1:0] pr_idx_t;
    typedef logic [$clog2(ROB_SIZE)-1:0]  rob_idx_t;
    // occupancy counts need one more bit than the index
    typedef logic [$clog2(ROB_SIZE):0]    rob_cnt_t;
    typedef logic [$clog2(IBUF_DEPTH)-1:0] ibuf_ptr_t;
    typedef logic [$clog2(IBUF_DEPTH):0]   ibuf_cnt_t;
    typedef logic [$clog2(FREE_REGS)-1:0]  fl_ptr_t;
    typedef logic [$clog2(FREE_REGS):0]    fl_cnt_t;

    // renamed instruction leaving on the dispatch port
    typedef struct packed {
        isa_pkg::fu_op_t   op;
        pr_idx_t           pdst;
        pr_idx_t           old_pdst;
        pr_idx_t           psrc1;
        pr_idx_t           psrc2;
        logic              use_rs2;
        logic              writes_rd;
        isa_pkg::imm_t     imm;
        rob_idx_t          rob_idx;
        isa_pkg::reg_idx_t rd;
    } disp_info_t;

    typedef struct packed {
        isa_pkg::reg_idx_t rd;
        pr_idx_t           pdst;
        pr_idx_t           old_pdst;
        logic              writes_rd;
        logic              done;
        logic              illegal;
    } rob_entry_t;

    typedef struct packed {
        rob_idx_t          rob_idx;
        isa_pkg::reg_idx_t rd;
        pr_idx_t           pdst;
        logic              writes_rd;
        logic              illegal;
    } commit_info_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

    // RV32I major opcodes handled by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // architectural register field
    typedef logic [4:0] reg_idx_t;

    // immediate as carried down the pipe, wide enough for the LUI field
    typedef logic [19:0] imm_t;

    // R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I-type layout, upper bits also give the U-type field
    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one fetched word seen through either layout
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_t;

    typedef enum logic [1:0] {
        ALU_REG,
        ALU_IMM,
        ALU_LUI,
        ILLEGAL
    } fu_op_t;

    typedef struct packed {
        fu_op_t   op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_rs2;
        logic     writes_rd;
        imm_t     imm;
    } dec_info_t;

endpackage
